// ==== list.f ====
+incdir+.
cpu_test_pkg.sv
cpu_test_rom.sv
cpu_test_pattern.sv
cpu_test_fetch.sv
cpu_test_exec.sv
cpu_test_bus.sv
cpu_test_top.sv
tb_clock.sv
tb_cpu_test.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_cpu_test \
   && ./obj_dir/Vtb_cpu_test 2>&1 | tee /dev/stderr | grep -q "Simulation passed" \
   || exit 1

// ==== tb_cpu_test.sv ====
// testbench for the microcoded test sequencer
// bus target with RAM and status register, a clean run and a corrupted run,
// checked by concurrent assertions
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module tb_cpu_test
   import cpu_test_pkg::*;
();

   localparam int HALT_TIMEOUT = 50000;

   typedef enum logic [1:0] {T_IDLE, T_DELAY, T_ACK} tgt_state_t;

   logic                  clk;
   logic                  reset;
   logic                  soft_reset;
   logic                  dut_reset;
   logic                  start;
   logic                  corrupt;
   logic                  done;
   logic                  fault;
   logic [`CT_PC_W-1:0]   pc;
   bus_req_t              bus_req;
   bus_rsp_t              bus_rsp = '0;

   logic [`CT_DATA_W-1:0] ram [0:`CT_FILL_WORDS-1];
   tgt_state_t            tgt_state;
   logic [1:0]            delay_cnt;
   logic [1:0]            busy_reads;
   logic [31:0]           rnd;
   integer                seed = 32'hf6635726;
   logic [`CT_ADDR_W-1:0] offs;
   logic [7:0]            idx;
   logic                  in_fill;
   logic [`CT_DATA_W-1:0] rd_value;

   logic                  rq_prev;
   logic                  req_start;
   logic                  wr_fill;
   logic                  rd_fill;
   logic [15:0]           fill_writes;
   logic [15:0]           fill_reads;
   logic [7:0]            status_reads;
   logic                  go_seen;
   logic [`CT_PC_W-1:0]   pc_prev;
   logic [`CT_ADDR_W-1:0] exp_fill_addr;
   logic [`CT_ADDR_W-1:0] exp_read_addr;
   logic [`CT_DATA_W-1:0] exp_fill_data;

   tb_clock i_clock
   (
      .clk   (clk),
      .reset (reset)
   );

   assign dut_reset = reset || soft_reset;

   cpu_test_top i_dut
   (
      .clk     (clk),
      .reset   (dut_reset),
      .start   (start),
      .done    (done),
      .fault   (fault),
      .pc      (pc),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   task automatic check_failed(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
      $display("FAIL %s expected %0h actual %0h", test, expected, actual);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic run_aborted(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // bus target

   initial
   begin
      for (int i = 0; i < `CT_FILL_WORDS; i++)
         ram[i] = 32'hc0de0000 | i;   // differs from every pattern word
   end

   assign offs    = bus_req.addr - `CT_FILL_BASE;
   assign idx     = offs[7:0];
   assign in_fill = (bus_req.addr >= `CT_FILL_BASE) &&
                    (bus_req.addr < `CT_FILL_BASE + `CT_FILL_WORDS);

   always_comb
   begin
      if (in_fill)
         rd_value = ram[idx] ^ ((corrupt && idx == 8'd100) ? 32'h10 : 32'h0);
      else if (bus_req.addr == `CT_REG_STATUS)
         rd_value = {31'b0, busy_reads != 2'd0};   // bit 0 busy
      else
         rd_value = '0;
   end

   always @(posedge clk)
   begin
      if (dut_reset)
      begin
         bus_rsp    <= '0;
         tgt_state  <= T_IDLE;
         delay_cnt  <= '0;
         busy_reads <= '0;
      end
      else
      begin
         bus_rsp.done <= 1'b0;
         case (tgt_state)
            T_IDLE:
               if (bus_req.rq)
               begin
                  rnd = $random(seed);
                  delay_cnt <= rnd[1:0];   // ack 1 to 4 cycles later
                  tgt_state <= T_DELAY;
               end
            T_DELAY:
               if (delay_cnt == 2'd0)
               begin
                  bus_rsp.ack <= 1'b1;
                  tgt_state   <= T_ACK;
               end
               else
               begin
                  delay_cnt <= delay_cnt - 2'd1;
               end
            default:
            begin
               bus_rsp.ack   <= 1'b0;
               bus_rsp.done  <= 1'b1;
               bus_rsp.rdata <= rd_value;
               tgt_state     <= T_IDLE;
               if (bus_req.wr && in_fill)
                  ram[idx] <= bus_req.wdata;
               else if (bus_req.wr && bus_req.addr == `CT_REG_GO)
                  busy_reads <= 2'd3;
               else if (!bus_req.wr && bus_req.addr == `CT_REG_STATUS && busy_reads != 2'd0)
                  busy_reads <= busy_reads - 2'd1;
            end
         endcase
      end
   end

   // transaction bookkeeping

   assign req_start     = bus_req.rq && !rq_prev;
   assign wr_fill       = req_start && bus_req.wr && in_fill;
   assign rd_fill       = req_start && !bus_req.wr && in_fill;
   assign exp_fill_addr = `CT_FILL_BASE + `CT_ADDR_W'(fill_writes);
   assign exp_read_addr = `CT_FILL_BASE + `CT_ADDR_W'(fill_reads);
   assign exp_fill_data = {4{fill_writes[7:0]}};

   always @(posedge clk)
   begin
      if (dut_reset)
      begin
         rq_prev      <= 1'b0;
         fill_writes  <= '0;
         fill_reads   <= '0;
         status_reads <= '0;
         go_seen      <= 1'b0;
         pc_prev      <= '1;
      end
      else
      begin
         rq_prev <= bus_req.rq;
         pc_prev <= pc;
         if (wr_fill)
            fill_writes <= fill_writes + 16'd1;
         if (rd_fill)
            fill_reads <= fill_reads + 16'd1;
         if (req_start && bus_req.wr && bus_req.addr == `CT_REG_GO)
            go_seen <= 1'b1;
         if (req_start && !bus_req.wr && bus_req.addr == `CT_REG_STATUS)
            status_reads <= status_reads + 8'd1;
      end
   end

   // checks

   chk_hold: assert property (@(posedge clk) disable iff (dut_reset)
      !start |-> !bus_req.rq && !done && !fault)
      else check_failed("reset_hold", 32'h0, $sampled({bus_req.rq, done, fault}));

   // pc sits at all ones until start and freezes once halted
   chk_pc_idle: assert property (@(posedge clk) disable iff (dut_reset)
      !start |-> pc == {`CT_PC_W{1'b1}})
      else check_failed("pc_idle", {`CT_PC_W{1'b1}}, $sampled(pc));

   chk_pc_halt: assert property (@(posedge clk) disable iff (dut_reset)
      (done || fault) |=> pc == pc_prev)
      else check_failed("pc_halt", $sampled(pc_prev), $sampled(pc));

   chk_rq_rise: assert property (@(posedge clk) disable iff (dut_reset)
      $rose(bus_req.rq) |-> !bus_rsp.ack)
      else check_failed("rq_rise_ack", 32'h0, $sampled(bus_rsp.ack));

   chk_wr_rq: assert property (@(posedge clk) disable iff (dut_reset)
      bus_req.wr |-> bus_req.rq)
      else check_failed("wr_without_rq", 32'h1, $sampled(bus_req.rq));

   chk_rq_fall: assert property (@(posedge clk) disable iff (dut_reset)
      bus_req.rq && bus_rsp.ack |=> !bus_req.rq)
      else check_failed("rq_fall", 32'h0, $sampled(bus_req.rq));

   chk_fill_addr: assert property (@(posedge clk) disable iff (dut_reset)
      wr_fill |-> bus_req.addr == exp_fill_addr)
      else check_failed("fill_addr", $sampled(exp_fill_addr), $sampled(bus_req.addr));

   chk_fill_data: assert property (@(posedge clk) disable iff (dut_reset)
      wr_fill |-> bus_req.wdata == exp_fill_data)
      else check_failed("fill_data", $sampled(exp_fill_data), $sampled(bus_req.wdata));

   chk_go_first: assert property (@(posedge clk) disable iff (dut_reset)
      rd_fill |-> go_seen)
      else check_failed("go_before_read", 32'h1, $sampled(go_seen));

   chk_poll: assert property (@(posedge clk) disable iff (dut_reset)
      rd_fill && fill_reads == 16'd0 |-> status_reads >= 8'd4)
      else check_failed("status_polls", 32'h4, $sampled(status_reads));

   chk_fill_count: assert property (@(posedge clk) disable iff (dut_reset)
      rd_fill && fill_reads == 16'd0 |-> fill_writes == 16'(`CT_FILL_WORDS))
      else check_failed("fill_count", `CT_FILL_WORDS, $sampled(fill_writes));

   chk_read_addr: assert property (@(posedge clk) disable iff (dut_reset)
      rd_fill |-> bus_req.addr == exp_read_addr)
      else check_failed("read_addr", $sampled(exp_read_addr), $sampled(bus_req.addr));

   chk_done_reads: assert property (@(posedge clk) disable iff (dut_reset)
      $rose(done) |-> fill_reads == 16'(`CT_FILL_WORDS))
      else check_failed("done_reads", `CT_FILL_WORDS, $sampled(fill_reads));

   // done only on the clean run, with the bus idle
   chk_done_quiet: assert property (@(posedge clk) disable iff (dut_reset)
      done |-> !fault && !bus_req.rq && !corrupt)
      else check_failed("done_state", 32'h0, $sampled({fault, bus_req.rq, corrupt}));

   chk_done_holds: assert property (@(posedge clk) disable iff (dut_reset)
      done |=> done)
      else check_failed("done_holds", 32'h1, $sampled(done));

   chk_fault_rise: assert property (@(posedge clk) disable iff (dut_reset)
      $rose(fault) |-> corrupt && fill_reads == 16'd101)
      else check_failed("fault_reads", {1'b1, 8'd101}, $sampled({corrupt, fill_reads[7:0]}));

   chk_fault_holds: assert property (@(posedge clk) disable iff (dut_reset)
      fault |=> fault && !bus_req.rq)
      else check_failed("fault_holds", 32'h2, $sampled({fault, bus_req.rq}));

   // stimulus

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (dut_reset !== 1'b0 && cycles < 100)
      begin
         @(posedge clk);
         cycles++;
      end
      if (dut_reset !== 1'b0)
         run_aborted("reset never released");
   endtask

   task automatic wait_halt(input logic on_fault);
      int cycles;
      cycles = 0;
      while ((on_fault ? !fault : !done) && cycles < HALT_TIMEOUT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (on_fault ? !fault : !done)
         run_aborted(on_fault ? "timeout waiting for fault" : "timeout waiting for done");
   endtask

   initial
   begin
      start      = 1'b0;
      corrupt    = 1'b0;
      soft_reset = 1'b0;

      // clean run
      wait_reset_release();
      repeat (50) @(posedge clk);   // start held low
      start <= 1'b1;
      wait_halt(1'b0);
      repeat (20) @(posedge clk);

      // second run with word 100 corrupted on readback
      soft_reset <= 1'b1;
      corrupt    <= 1'b1;
      start      <= 1'b0;
      repeat (4) @(posedge clk);
      soft_reset <= 1'b0;
      wait_reset_release();
      repeat (50) @(posedge clk);
      start <= 1'b1;
      wait_halt(1'b1);
      repeat (20) @(posedge clk);

      if (fault && !done)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
      begin
         run_aborted("sequencer left its fault halt");
      end
   end

endmodule

// ==== tb_clock.sv ====
// testbench clock and power-on reset
// 40 ns clock, reset high for the first 4 cycles
`timescale 1ns/1ps

module tb_clock
(
   output logic clk,
   output logic reset
);

   always
   begin
      clk = 1'b0;
      #20;
      clk = 1'b1;
      #20;
   end

   initial
   begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// ==== cpu_test_top.sv ====
// microcoded test sequencer
// fetch, execute and bus stages driving an external req/ack bus
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_top
   import cpu_test_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   output logic                done,
   output logic                fault,
   output logic [`CT_PC_W-1:0] pc,
   output bus_req_t            bus_req,
   input  bus_rsp_t            bus_rsp
);

   micro_inst_t           inst;
   mem_op_t               mem;
   logic                  stall;
   logic                  load;
   logic [5:0]            target;
   logic [`CT_ADDR_W-1:0] addr;
   logic [`CT_DATA_W-1:0] wdata;
   logic [`CT_DATA_W-1:0] rdata;
   logic                  mem_done;

   cpu_test_fetch i_fetch
   (
      .clk    (clk),
      .reset  (reset),
      .stall  (stall),
      .load   (load),
      .target (target),
      .inst   (inst),
      .pc     (pc)
   );

   cpu_test_exec i_exec
   (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .inst     (inst),
      .mem_done (mem_done),
      .rdata    (rdata),
      .stall    (stall),
      .load     (load),
      .target   (target),
      .mem      (mem),
      .addr     (addr),
      .wdata    (wdata),
      .done     (done),
      .fault    (fault)
   );

   cpu_test_bus i_bus
   (
      .clk      (clk),
      .reset    (reset),
      .mem      (mem),
      .addr     (addr),
      .wdata    (wdata),
      .mem_done (mem_done),
      .rdata    (rdata),
      .req      (bus_req),
      .rsp      (bus_rsp)
   );

endmodule

// ==== cpu_test_bus.sv ====
// bus stage
// request/acknowledge FSM between the execute stage and the target
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_bus
   import cpu_test_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  mem_op_t               mem,
   input  logic [`CT_ADDR_W-1:0] addr,
   input  logic [`CT_DATA_W-1:0] wdata,
   output logic                  mem_done,
   output logic [`CT_DATA_W-1:0] rdata,
   output bus_req_t              req,
   input  bus_rsp_t              rsp
);

   typedef enum logic [1:0] {M_IDLE, M_REQ, M_WAIT, M_DONE} mstate_t;

   mstate_t state;
   mstate_t state_nx;
   logic    rq_q;
   logic    wr_q;

   always_comb
   begin
      state_nx = state;
      case (state)
         M_IDLE: if (mem.rd || mem.wr) state_nx = M_REQ;
         M_REQ:  if (rsp.ack) state_nx = M_WAIT;
         M_WAIT: if (!rsp.ack) state_nx = M_DONE;
         M_DONE: state_nx = M_IDLE;
         default: state_nx = M_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= M_IDLE;
         rq_q  <= 1'b0;
         wr_q  <= 1'b0;
      end
      else
      begin
         state <= state_nx;
         rq_q  <= (state == M_REQ) && !rsp.ack;   // drops the cycle after ack
         wr_q  <= (state == M_REQ) && !rsp.ack && mem.wr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rsp.done)
         rdata <= rsp.rdata;
   end

   assign mem_done  = state == M_DONE;
   assign req.rq    = rq_q;
   assign req.wr    = wr_q;
   assign req.addr  = addr;
   assign req.wdata = wdata;

   a_rq_after_ack: assert property (@(posedge clk) disable iff (reset)
      $rose(req.rq) |-> !rsp.ack);

   a_wr_with_rq: assert property (@(posedge clk) disable iff (reset)
      req.wr |-> req.rq);

endmodule

// ==== cpu_test_exec.sv ====
// execute stage
// registers a..d, add/sub, branch tests, WAIT counter and halt latches
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_exec
   import cpu_test_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  micro_inst_t           inst,
   input  logic                  mem_done,
   input  logic [`CT_DATA_W-1:0] rdata,
   output logic                  stall,
   output logic                  load,
   output logic [5:0]            target,
   output mem_op_t               mem,
   output logic [`CT_ADDR_W-1:0] addr,
   output logic [`CT_DATA_W-1:0] wdata,
   output logic                  done,
   output logic                  fault
);

   localparam int WAIT_W = $clog2(`CT_WAIT_CYCLES);

   logic [`CT_ADDR_W-1:0] a;
   logic [`CT_DATA_W-1:0] b;
   logic [`CT_DATA_W-1:0] c;
   logic [`CT_DATA_W-1:0] d;
   logic [`CT_DATA_W-1:0] pat;
   logic [`CT_DATA_W-1:0] src;
   logic [`CT_DATA_W-1:0] dst;
   logic [`CT_DATA_W-1:0] alu;
   logic [WAIT_W-1:0]     wait_cnt;
   logic                  wait_done;
   logic                  run;
   logic                  bus_op;

   cpu_test_pattern i_pattern
   (
      .clk   (clk),
      .reset (reset),
      .index (a[7:0]),
      .data  (pat)
   );

   always_comb
   begin
      case (inst.sreg)
         R_A:     src = `CT_DATA_W'(a);
         R_B:     src = b;
         R_C:     src = c;
         R_D:     src = d;
         R_I:     src = inst.imm;
         R_DD:    src = pat;
         default: src = '0;
      endcase
      case (inst.dreg)
         R_A:     dst = `CT_DATA_W'(a);
         R_B:     dst = b;
         R_C:     dst = c;
         R_D:     dst = d;
         default: dst = '0;
      endcase
   end

   assign alu    = (inst.op == OP_SUB) ? src - inst.imm : src + inst.imm;
   assign run    = start && !done && !fault;
   assign bus_op = (inst.op == OP_READ) || (inst.op == OP_WRITE);

   assign wait_done = wait_cnt == WAIT_W'(`CT_WAIT_CYCLES - 1);

   // halt ops stall too, so pc parks on them
   assign stall = !run
                  || (inst.op == OP_DONE) || (inst.op == OP_FAULT)
                  || (inst.op == OP_WAIT && !wait_done)
                  || (bus_op && !mem_done);

   assign load = (inst.op == OP_JMP)
                 || (inst.op == OP_TST && ~|(dst & src))   // zero and
                 || (inst.op == OP_CMP && dst == src);

   assign target = inst.next;
   assign mem.rd = run && (inst.op == OP_READ);
   assign mem.wr = run && (inst.op == OP_WRITE);
   assign addr   = a;
   assign wdata  = d;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         a        <= '0;
         b        <= '0;
         c        <= '0;
         d        <= '0;
         wait_cnt <= '0;
         done     <= 1'b0;
         fault    <= 1'b0;
      end
      else
      begin
         if (mem_done && inst.op == OP_READ)
         begin
            d <= rdata;
         end
         else if (run && (inst.op == OP_ADD || inst.op == OP_SUB))
         begin
            case (inst.dreg)
               R_A:     a <= alu[`CT_ADDR_W-1:0];
               R_B:     b <= alu;
               R_C:     c <= alu;
               R_D:     d <= alu;
               default: ;
            endcase
         end
         if (run && inst.op == OP_WAIT)
            wait_cnt <= wait_cnt + 1'b1;
         else
            wait_cnt <= '0;
         if (run && inst.op == OP_DONE)
            done <= 1'b1;
         if (run && inst.op == OP_FAULT)
            fault <= 1'b1;
      end
   end

   a_no_load_with_bus: assert property (@(posedge clk) disable iff (reset)
      !(load && (mem.rd || mem.wr)));

endmodule

// ==== cpu_test_fetch.sv ====
// fetch stage
// program counter and next-pc select driving the registered ROM
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_fetch
   import cpu_test_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                stall,
   input  logic                load,
   input  logic [5:0]          target,
   output micro_inst_t         inst,
   output logic [`CT_PC_W-1:0] pc
);

   logic [`CT_PC_W-1:0] npc;
   logic [`CT_PC_W-1:0] rom_addr;

   assign npc = load ? `CT_PC_W'(target) : pc + 1'b1;

   // re-read the current word while stalled so inst stays with pc
   assign rom_addr = stall ? pc : npc;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc <= '1;   // first fetch lands on 0
      end
      else if (!stall)
      begin
         pc <= npc;
      end
   end

   cpu_test_rom i_rom
   (
      .clk   (clk),
      .reset (reset),
      .addr  (rom_addr),
      .data  (inst)
   );

endmodule

// ==== cpu_test_pattern.sv ====
// expected data source
// word k carries k in every byte, one cycle after the index
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_pattern
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [7:0]            index,
   output logic [`CT_DATA_W-1:0] data
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         data <= '0;
      end
      else
      begin
         data <= {4{index}};   // byte replicated
      end
   end

endmodule

// ==== cpu_test_rom.sv ====
// microcode ROM for the test sequencer
// fill, kick the go register, poll status, read back and compare
`timescale 1ns/1ps
`include "cpu_test_params.svh"

module cpu_test_rom
   import cpu_test_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic [`CT_PC_W-1:0] addr,
   output micro_inst_t         data
);

   function automatic micro_inst_t ui(input op_t op, input rsel_t dreg, input rsel_t sreg,
                                      input logic [5:0] next, input logic [31:0] imm);
      return '{op, dreg, sreg, next, imm};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         data <= '0;
      end
      else
      begin
         case (addr)
            // fill region with the pattern
            8'h00: data <= ui(OP_ADD,   R_A,    R_NONE, 6'h00, `CT_FILL_BASE);
            8'h01: data <= ui(OP_ADD,   R_B,    R_NONE, 6'h00, 32'h0);   // b = count
            8'h02: data <= ui(OP_ADD,   R_D,    R_DD,   6'h00, 32'h0);   // d = pattern
            8'h03: data <= ui(OP_WRITE, R_NONE, R_NONE, 6'h00, 32'h0);   // m[a] = d
            8'h04: data <= ui(OP_ADD,   R_A,    R_A,    6'h00, 32'h1);
            8'h05: data <= ui(OP_ADD,   R_B,    R_B,    6'h00, 32'h1);
            8'h06: data <= ui(OP_CMP,   R_B,    R_I,    6'h08, `CT_FILL_WORDS);
            8'h07: data <= ui(OP_JMP,   R_NONE, R_NONE, 6'h02, 32'h0);

            // go, then poll until busy clears
            8'h08: data <= ui(OP_ADD,   R_A,    R_NONE, 6'h00, `CT_REG_GO);
            8'h09: data <= ui(OP_ADD,   R_D,    R_NONE, 6'h00, 32'h1);
            8'h0a: data <= ui(OP_WRITE, R_NONE, R_NONE, 6'h00, 32'h0);
            8'h0b: data <= ui(OP_WAIT,  R_NONE, R_NONE, 6'h00, 32'h0);
            8'h0c: data <= ui(OP_ADD,   R_A,    R_NONE, 6'h00, `CT_REG_STATUS);
            8'h0d: data <= ui(OP_READ,  R_NONE, R_NONE, 6'h00, 32'h0);
            8'h0e: data <= ui(OP_TST,   R_D,    R_I,    6'h10, 32'h1);   // bit 0 clear
            8'h0f: data <= ui(OP_JMP,   R_NONE, R_NONE, 6'h0b, 32'h0);

            // read back and compare
            8'h10: data <= ui(OP_ADD,   R_A,    R_NONE, 6'h00, `CT_FILL_BASE);
            8'h11: data <= ui(OP_ADD,   R_B,    R_NONE, 6'h00, 32'h0);
            8'h12: data <= ui(OP_READ,  R_NONE, R_NONE, 6'h00, 32'h0);
            8'h13: data <= ui(OP_CMP,   R_D,    R_DD,   6'h15, 32'h0);   // match skips fault
            8'h14: data <= ui(OP_FAULT, R_NONE, R_NONE, 6'h00, 32'h0);
            8'h15: data <= ui(OP_ADD,   R_A,    R_A,    6'h00, 32'h1);
            8'h16: data <= ui(OP_ADD,   R_B,    R_B,    6'h00, 32'h1);
            8'h17: data <= ui(OP_CMP,   R_B,    R_I,    6'h19, `CT_FILL_WORDS);
            8'h18: data <= ui(OP_JMP,   R_NONE, R_NONE, 6'h12, 32'h0);
            8'h19: data <= ui(OP_DONE,  R_NONE, R_NONE, 6'h00, 32'h0);

            default: data <= ui(OP_JMP, R_NONE, R_NONE, 6'h00, 32'h0);
         endcase
      end
   end

endmodule

// ==== cpu_test_pkg.sv ====
// test sequencer types
// opcodes, register selects, the 48-bit microinstruction and the bus structs
`include "cpu_test_params.svh"

package cpu_test_pkg;

   typedef enum logic [3:0]
   {
      OP_NOP   = 4'd0,
      OP_WRITE = 4'd1,
      OP_READ  = 4'd2,
      OP_ADD   = 4'd3,
      OP_SUB   = 4'd4,
      OP_TST   = 4'd5,
      OP_CMP   = 4'd6,
      OP_JMP   = 4'd7,
      OP_DONE  = 4'd8,
      OP_WAIT  = 4'd9,
      OP_FAULT = 4'd15
   } op_t;

   typedef enum logic [2:0]
   {
      R_NONE = 3'd0,
      R_A    = 3'd1,
      R_B    = 3'd2,
      R_C    = 3'd3,
      R_D    = 3'd4,
      R_I    = 3'd5,   // immediate
      R_DD   = 3'd7    // pattern data
   } rsel_t;

   typedef struct packed
   {
      op_t         op;
      rsel_t       dreg;
      rsel_t       sreg;
      logic [5:0]  next;   // jump target
      logic [31:0] imm;
   } micro_inst_t;

   typedef struct packed
   {
      logic                  rq;
      logic                  wr;
      logic [`CT_ADDR_W-1:0] addr;
      logic [`CT_DATA_W-1:0] wdata;
   } bus_req_t;

   typedef struct packed
   {
      logic                  ack;
      logic                  done;
      logic [`CT_DATA_W-1:0] rdata;
   } bus_rsp_t;

   typedef struct packed
   {
      logic rd;
      logic wr;
   } mem_op_t;

endpackage

// ==== cpu_test_params.svh ====
// test sequencer constants
// widths, WAIT length and the addresses the test program touches
`ifndef CPU_TEST_PARAMS_SVH
`define CPU_TEST_PARAMS_SVH

`define CT_PC_W         8
`define CT_DATA_W       32
`define CT_ADDR_W       22
`define CT_WAIT_CYCLES  16

`define CT_FILL_BASE    22'h11000
`define CT_FILL_WORDS   256
`define CT_REG_GO       22'o17377777
`define CT_REG_STATUS   22'o17377770

`endif
